//--- rtl/fma_pkg.sv
// ----------------------------------------------------------------------
// Shared widths and types for the binary16 FMA array
// Only num_lanes is meant to change. Results truncate, no rounding
// ----------------------------------------------------------------------

`default_nettype none

package fma_pkg;

    // ------------------------------------------------------------------
    // Array shape and timing
    // ------------------------------------------------------------------
    localparam int num_lanes    = 4;
    localparam int lane_latency = 3;                   // Stages inside one lane
    localparam int fma_latency  = lane_latency + 2;    // Plus classifier and drain

    // ------------------------------------------------------------------
    // Binary16 format
    // ------------------------------------------------------------------
    localparam int exp_w    = 5;
    localparam int frac_w   = 10;
    localparam int sig_w    = frac_w + 1;              // Hidden bit included
    localparam int exp_bias = 15;

    localparam logic [15:0] canonical_nan = 16'h7C01;

    typedef logic [15:0]       fp16_t;
    typedef logic [exp_w-1:0]  fp16_exp_t;
    typedef logic [sig_w-1:0]  fp16_sig_t;

    // One unpacked operand
    typedef struct packed {
        logic      sign;
        fp16_exp_t exp;
        fp16_sig_t sig;      // Hidden bit set for normal numbers
        logic      is_nan;
        logic      is_inf;
        logic      is_zero;
    } fp16_class_t;

    // Operand set of one lane
    typedef struct packed {
        fp16_class_t a;
        fp16_class_t b;
        fp16_class_t c;
    } fma_operands_t;

    // Classification of one packed result
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic is_zero;
        logic is_subnormal;
    } lane_status_t;

endpackage

`default_nettype wire

//--- rtl/fma_operand_classify.sv
// ----------------------------------------------------------------------
// Unpacks a, b and c of every lane into fields and special flags
// One register stage. ops holds its value while in_valid is low
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fma_operand_classify
    import fma_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  fp16_t         [num_lanes-1:0]  a,
    input  fp16_t         [num_lanes-1:0]  b,
    input  fp16_t         [num_lanes-1:0]  c,
    output fma_operands_t [num_lanes-1:0]  ops,
    output logic                           ops_valid
);

    // Split one word and flag NaN, infinity and zero
    function automatic fp16_class_t split_word(input fp16_t w);
        fp16_class_t       r;
        logic [frac_w-1:0] frac;
        logic              exp_ones;
        logic              exp_zero;
        frac      = w[frac_w-1:0];
        r.sign    = w[15];
        r.exp     = w[frac_w +: exp_w];
        exp_ones  = (r.exp == '1);
        exp_zero  = (r.exp == '0);
        r.sig     = {!exp_zero, frac};           // Hidden bit only when exp is nonzero
        r.is_nan  = exp_ones && (frac != '0);
        r.is_inf  = exp_ones && (frac == '0);
        r.is_zero = exp_zero && (frac == '0);
        return r;
    endfunction

    // ------------------------------------------------------------------
    // Operand register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int i = 0; i < num_lanes; i++) begin
                ops[i].a <= split_word(a[i]);
                ops[i].b <= split_word(b[i]);
                ops[i].c <= split_word(c[i]);
            end
        end
    end

    // Valid follows the strobe by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ops_valid <= 1'b0;
        end else begin
            ops_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fp16_fma_lane.sv
// ----------------------------------------------------------------------
// One binary16 fused multiply-add lane, three register stages
// Truncates, no rounding. Subnormals use exponent 1 without hidden bit
// Datapath registers have no reset and the lane carries no valid bit
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fp16_fma_lane
    import fma_pkg::*;
(
    input  logic          clk,
    input  fma_operands_t ops,
    output fp16_t         lane_result
);

    // ------------------------------------------------------------------
    // Stage 1: significand product and special cases
    // ------------------------------------------------------------------
    logic [2*sig_w-1:0] prod;
    fp16_exp_t          eff_a;
    fp16_exp_t          eff_b;
    logic signed [6:0]  prod_exp;
    logic               prod_nan;
    logic               prod_inf;
    logic               prod_zero;
    logic               prod_sign;
    logic               special;
    fp16_t              special_word;

    logic               s1_special;
    fp16_t              s1_special_word;
    logic               s1_ps;
    logic signed [6:0]  s1_pe;           // Biased product exponent, may go negative
    logic [2*sig_w-1:0] s1_pm;           // 1.xxx with point below the MSB
    logic               s1_cs;
    fp16_exp_t          s1_ce;
    fp16_sig_t          s1_cm;

    always_comb begin
        prod      = ops.a.sig * ops.b.sig;
        eff_a     = (ops.a.exp == '0) ? fp16_exp_t'(1) : ops.a.exp;
        eff_b     = (ops.b.exp == '0) ? fp16_exp_t'(1) : ops.b.exp;
        prod_exp  = $signed({2'b00, eff_a}) + $signed({2'b00, eff_b}) - 7'(exp_bias);
        prod_sign = ops.a.sign ^ ops.b.sign;
        prod_nan  = ops.a.is_nan || ops.b.is_nan ||
                    (ops.a.is_inf && ops.b.is_zero) || (ops.a.is_zero && ops.b.is_inf);
        prod_inf  = ops.a.is_inf || ops.b.is_inf;
        prod_zero = ops.a.is_zero || ops.b.is_zero;

        special      = 1'b1;
        special_word = canonical_nan;
        if (prod_nan || ops.c.is_nan) begin
            special_word = canonical_nan;
        end else if (prod_inf && ops.c.is_inf && (prod_sign != ops.c.sign)) begin
            special_word = canonical_nan;                         // Inf minus inf
        end else if (prod_inf) begin
            special_word = {prod_sign, 5'h1F, 10'b0};
        end else if (ops.c.is_inf) begin
            special_word = {ops.c.sign, 5'h1F, 10'b0};
        end else if (prod_zero) begin
            special_word = {ops.c.sign, ops.c.exp, ops.c.sig[frac_w-1:0]};  // c as is
        end else begin
            special = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        s1_special      <= special;
        s1_special_word <= special_word;
        s1_ps           <= prod_sign;
        s1_pe           <= prod[2*sig_w-1] ? prod_exp + 7'sd1 : prod_exp;
        s1_pm           <= prod[2*sig_w-1] ? prod : prod << 1;
        s1_cs           <= ops.c.sign;
        s1_ce           <= (ops.c.exp == '0) ? fp16_exp_t'(1) : ops.c.exp;
        s1_cm           <= ops.c.sig;
    end

    // ------------------------------------------------------------------
    // Stage 2: align on a 48-bit bus and add
    // ------------------------------------------------------------------
    // Leading bit of both addends sits at bit 46, bit 47 takes the carry
    logic signed [6:0] ce_s;
    logic [6:0]        shamt;
    logic [47:0]       ab_al;
    logic [47:0]       c_al;
    logic signed [6:0] e_big;
    logic [47:0]       sum;
    logic              sum_sign;

    logic              s2_special;
    fp16_t             s2_special_word;
    logic              s2_sign;
    logic signed [6:0] s2_exp;
    logic [47:0]       s2_sum;

    always_comb begin
        ce_s = $signed({2'b00, s1_ce});
        if (s1_pe >= ce_s) begin
            e_big = s1_pe;
            shamt = s1_pe - ce_s;
            ab_al = {1'b0, s1_pm, 25'b0};
            c_al  = {1'b0, s1_cm, 36'b0} >> shamt;
        end else begin
            e_big = ce_s;
            shamt = ce_s - s1_pe;
            ab_al = {1'b0, s1_pm, 25'b0} >> shamt;
            c_al  = {1'b0, s1_cm, 36'b0};
        end

        if (s1_ps == s1_cs) begin
            sum      = ab_al + c_al;
            sum_sign = s1_ps;
        end else if (ab_al >= c_al) begin          // Ties keep the product sign
            sum      = ab_al - c_al;
            sum_sign = s1_ps;
        end else begin
            sum      = c_al - ab_al;
            sum_sign = s1_cs;
        end
    end

    always_ff @(posedge clk) begin
        s2_special      <= s1_special;
        s2_special_word <= s1_special_word;
        s2_sign         <= sum_sign;
        s2_exp          <= e_big;
        s2_sum          <= sum;
    end

    // ------------------------------------------------------------------
    // Stage 3: normalize and pack
    // ------------------------------------------------------------------
    logic [5:0]        lead;
    logic [47:0]       norm;
    logic signed [8:0] e_n;
    logic [8:0]        sub_sh;
    fp16_sig_t         sub_m;
    fp16_t             packed_word;

    always_comb begin
        lead = '0;
        for (int i = 0; i < 48; i++) begin
            if (s2_sum[i]) lead = 6'(i);        // Highest set bit wins
        end
        norm   = s2_sum << (6'd47 - lead);      // Leading one to bit 47
        e_n    = s2_exp + $signed({3'b000, lead}) - 9'sd46;
        sub_sh = '0;
        sub_m  = '0;

        if (s2_special) begin
            packed_word = s2_special_word;
        end else if (s2_sum == '0) begin
            packed_word = {s2_sign, 15'b0};
        end else if (e_n >= 9'sd31) begin
            packed_word = {s2_sign, 5'h1F, 10'b0};               // Overflow
        end else if (e_n >= 9'sd1) begin
            packed_word = {s2_sign, e_n[exp_w-1:0], norm[46:37]};
        end else begin
            // Subnormal or signed zero
            sub_sh      = 9'sd1 - e_n;
            sub_m       = norm[47:37] >> sub_sh;
            packed_word = {s2_sign, 5'b0, sub_m[frac_w-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        lane_result <= packed_word;
    end

endmodule

`default_nettype wire

//--- rtl/fma_result_drain.sv
// ----------------------------------------------------------------------
// Output register for all lanes with a per-lane status
// Valid is delayed here by the fixed lane latency
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fma_result_drain
    import fma_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ops_valid,
    input  fp16_t        [num_lanes-1:0]  lane_result,
    output fp16_t        [num_lanes-1:0]  result,
    output lane_status_t [num_lanes-1:0]  status,
    output logic                          out_valid
);

    logic [lane_latency-1:0] valid_dly;    // Tracks the lane pipeline

    // Status from the exponent and fraction fields
    function automatic lane_status_t classify_result(input fp16_t w);
        lane_status_t      s;
        fp16_exp_t         e;
        logic [frac_w-1:0] f;
        e              = w[frac_w +: exp_w];
        f              = w[frac_w-1:0];
        s.is_nan       = (e == '1) && (f != '0);
        s.is_inf       = (e == '1) && (f == '0);
        s.is_zero      = (e == '0) && (f == '0);
        s.is_subnormal = (e == '0) && (f != '0);
        return s;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_dly <= '0;
            out_valid <= 1'b0;
            result    <= '0;
            status    <= '0;
        end else begin
            valid_dly <= {valid_dly[lane_latency-2:0], ops_valid};
            out_valid <= valid_dly[lane_latency-1];
            if (valid_dly[lane_latency-1]) begin        // Lane outputs are current
                for (int i = 0; i < num_lanes; i++) begin
                    result[i] <= lane_result[i];
                    status[i] <= classify_result(lane_result[i]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fp16_fma_array.sv
// ----------------------------------------------------------------------
// Top of the binary16 FMA array: classifier, lanes and drain
// A new operand set may enter on every cycle, no back-pressure
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fp16_fma_array
    import fma_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  fp16_t        [num_lanes-1:0]  a,
    input  fp16_t        [num_lanes-1:0]  b,
    input  fp16_t        [num_lanes-1:0]  c,
    output fp16_t        [num_lanes-1:0]  result,
    output lane_status_t [num_lanes-1:0]  status,
    output logic                          out_valid
);

    fma_operands_t [num_lanes-1:0] ops;
    logic                          ops_valid;
    fp16_t         [num_lanes-1:0] lane_result;

    fma_operand_classify u_classify (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .ops       (ops),
        .ops_valid (ops_valid)
    );

    // One lane per operand set
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        fp16_fma_lane u_lane (
            .clk         (clk),
            .ops         (ops[i]),
            .lane_result (lane_result[i])
        );
    end

    fma_result_drain u_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .ops_valid   (ops_valid),
        .lane_result (lane_result),
        .result      (result),
        .status      (status),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

//--- tb/tb_fp16_fma_array.sv
// ----------------------------------------------------------------------
// Self-checking testbench for the binary16 FMA array
// Vectors and expected words come from tb/fma_golden.hex, run from root
// Status is rebuilt here from the fields of each expected word
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_fp16_fma_array
    import fma_pkg::*;
();

    localparam int num_vec     = 12;
    localparam int group_size  = 3;        // Vectors issued back to back
    localparam int cycle_limit = num_vec * 2 + fma_latency + 50;

    logic                          clk;
    logic                          rst_n;
    logic                          in_valid;
    fp16_t        [num_lanes-1:0]  a;
    fp16_t        [num_lanes-1:0]  b;
    fp16_t        [num_lanes-1:0]  c;
    fp16_t        [num_lanes-1:0]  result;
    lane_status_t [num_lanes-1:0]  status;
    logic                          out_valid;

    // a0..a3, b0..b3, c0..c3, r0..r3 from the MSB down
    logic [255:0] golden [0:num_vec-1];

    int     pend_idx[$];
    int     pend_cycle[$];
    int     cycle;
    int     run_cycles;
    int     checked;
    int     tests_passed;
    int     tests_failed;
    int     misc_errors;
    integer seed;

    fp16_fma_array dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .c         (c),
        .result    (result),
        .status    (status),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Field rules of binary16
    function automatic lane_status_t status_from_word(input fp16_t w);
        lane_status_t s;
        s.is_nan       = (w[14:10] == 5'h1F) && (w[9:0] != 10'b0);
        s.is_inf       = (w[14:10] == 5'h1F) && (w[9:0] == 10'b0);
        s.is_zero      = (w[14:10] == 5'h00) && (w[9:0] == 10'b0);
        s.is_subnormal = (w[14:10] == 5'h00) && (w[9:0] != 10'b0);
        return s;
    endfunction

    function automatic fp16_t field_of(input int v, input int k);
        return golden[v][255-16*k -: 16];
    endfunction

    // ------------------------------------------------------------------
    // Cycle count and timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst_n) run_cycles <= run_cycles + 1;
        if (run_cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles with %0d of %0d vectors checked",
                     run_cycles, checked, num_vec);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Result checker, samples away from the rising edge
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        int    v;
        int    bad;
        fp16_t exp_w;
        lane_status_t exp_s;
        string name;
        if (cycle > 1 && out_valid !== 1'b0 && pend_idx.size() == 0) begin
            $display("out_valid is high at cycle %0d with no vector in flight", cycle);
            misc_errors++;
        end
        if (pend_idx.size() != 0) begin
            if (out_valid === 1'b1) begin
                v   = pend_idx.pop_front();
                bad = 0;
                if (cycle - pend_cycle[0] != fma_latency) begin
                    $display("vec%0d came out after %0d cycles instead of %0d",
                             v, cycle - pend_cycle[0], fma_latency);
                    bad++;
                end
                void'(pend_cycle.pop_front());
                for (int l = 0; l < num_lanes; l++) begin
                    exp_w = field_of(v, 12 + l);
                    exp_s = status_from_word(exp_w);
                    name  = $sformatf("vec%0d lane%0d", v, l);
                    if (result[l] !== exp_w) begin
                        $display("Error %s result: expected %h actual %h",
                                 name, exp_w, result[l]);
                        bad++;
                    end
                    if (status[l] !== exp_s) begin
                        $display("Error %s status: expected %b actual %b",
                                 name, exp_s, status[l]);
                        bad++;
                    end
                end
                if (bad == 0) begin
                    tests_passed++;
                    $display("vec%0d: pass", v);
                end else begin
                    tests_failed++;
                    $display("vec%0d: fail with %0d mismatches", v, bad);
                end
                checked++;
            end else if (cycle - pend_cycle[0] > fma_latency) begin
                $display("vec%0d got no out_valid within %0d cycles", pend_idx[0], fma_latency);
                void'(pend_idx.pop_front());
                void'(pend_cycle.pop_front());
                tests_failed++;
                checked++;
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        int gap;
        seed         = 32'h207d_1466;
        cycle        = 0;
        run_cycles   = 0;
        checked      = 0;
        tests_passed = 0;
        tests_failed = 0;
        misc_errors  = 0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        a            = '0;
        b            = '0;
        c            = '0;
        $readmemh("tb/fma_golden.hex", golden);
        if ($isunknown(golden[num_vec-1])) begin
            $display("Golden vectors could not be read from tb/fma_golden.hex");
            misc_errors++;
        end
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        for (int v = 0; v < num_vec; v++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            for (int l = 0; l < num_lanes; l++) begin
                a[l] = field_of(v, l);
                b[l] = field_of(v, 4 + l);
                c[l] = field_of(v, 8 + l);
            end
            pend_idx.push_back(v);
            pend_cycle.push_back(cycle);        // Cycle in which the strobe is high
            if (v % group_size == group_size - 1) begin
                gap = 1 + {$random(seed)} % 6;  // Idle cycles between groups
                for (int g = 0; g < gap; g++) begin
                    @(posedge clk);
                    #1 in_valid = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1 in_valid = 1'b0;

        wait (checked == num_vec);
        repeat (fma_latency + 2) @(posedge clk);
        $display("Tests passed %0d, failed %0d, other errors %0d",
                 tests_passed, tests_failed, misc_errors);
        if (tests_failed == 0 && misc_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/fma_golden.hex
// Columns: a0 a1 a2 a3 b0 b1 b2 b3 c0 c1 c2 c3 r0 r1 r2 r3, binary16 words
// Results are a*b+c fused and truncated, special words per the lane rules
// Normal sums, same and opposite signs, cancellation
3C00_4000_3E00_BC00_3C00_4200_4000_3C00_3C00_3C00_BC00_3C00_4000_4700_4000_8000
3C01_3C00_4200_4200_3C01_3C00_4200_4200_0000_8C00_C500_C900_3C02_3BFF_4400_BC00
// NaN, infinity and zero product cases
7E00_7C00_7C00_FC00_3C00_0000_3C00_4000_3C00_3C00_FC00_3C00_7C01_7C01_7C01_FC00
3C00_3C00_0000_8000_3C00_3C00_3C00_4000_FC00_7C01_C200_3555_FC00_7C01_C200_3555
// Negative zero c, small difference, overflow
3C00_3C01_7BFF_FBFF_4000_3C01_4000_7BFF_8000_BC00_0000_0000_4000_1800_7C00_FC00
// Underflow and subnormal operands
0400_0400_0001_8001_3800_0400_4000_4000_0000_0000_0000_0000_0200_0000_0002_8002
// Same cases moved by one lane
4000_3E00_BC00_3C00_4200_4000_3C00_3C00_3C00_BC00_3C00_3C00_4700_4000_8000_4000
7C00_7C00_FC00_7E00_0000_3C00_4000_3C00_3C00_FC00_3C00_3C00_7C01_7C01_FC00_7C01
0400_0001_8001_0400_0400_4000_4000_3800_0000_0000_0000_0000_0000_0002_8002_0200
3C00_4200_4200_3C01_3C00_4200_4200_3C01_8C00_C500_C900_0000_3BFF_4400_BC00_3C02
3C01_7BFF_FBFF_3C00_3C01_4000_7BFF_4000_BC00_0000_0000_8000_1800_7C00_FC00_4000
3C00_0000_8000_3C00_3C00_3C00_4000_3C00_7C01_C200_3555_FC00_7C01_C200_3555_FC00

//--- files.f
rtl/fma_pkg.sv
rtl/fma_operand_classify.sv
rtl/fp16_fma_lane.sv
rtl/fma_result_drain.sv
rtl/fp16_fma_array.sv
tb/tb_fp16_fma_array.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary -j 0
TOP        ?= tb_fp16_fma_array
RTL_TOP    ?= fp16_fma_array
FILELIST   ?= files.f
LOG        ?= sim.log
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
